// ==== bench/core_stimulus.txt ====
# P <byte address> <instruction word>
# E <group 1 alu, 2 addi, 3 mem, 4 beq, 5 x0> <pc> <rd> <write data>
P 00000000 00C00093
P 00000004 FF900113
P 00000008 002081B3
P 0000000C 40110233
P 00000010 0020F2B3
P 00000014 0020E333
P 00000018 0020C3B3
P 0000001C 00112433
P 00000020 002224B3
P 00000024 0020A533
P 00000028 05500013
P 0000002C 001005B3
P 00000030 0040A823
P 00000034 0030A823
P 00000038 01C02603
P 0000003C FE60AE23
P 00000040 00802683
P 00000044 00C18463
P 00000048 00100713
P 0000004C 00208463
P 00000050 80160793
P 00000054 7FF78813
P 00000058 00000063
E 2 00000000 01 0000000C
E 2 00000004 02 FFFFFFF9
E 1 00000008 03 00000005
E 1 0000000C 04 FFFFFFED
E 1 00000010 05 00000008
E 1 00000014 06 FFFFFFFD
E 1 00000018 07 FFFFFFF5
E 1 0000001C 08 00000001
E 1 00000020 09 00000001
E 1 00000024 0A 00000000
E 5 00000028 00 00000055
E 5 0000002C 0B 0000000C
E 3 00000030 00 00000000
E 3 00000034 00 00000000
E 3 00000038 0C 00000005
E 3 0000003C 00 00000000
E 3 00000040 0D FFFFFFFD
E 4 00000044 00 00000000
E 4 0000004C 00 00000000
E 2 00000050 0F FFFFF806
E 2 00000054 10 00000005
E 4 00000058 00 00000000
E 4 00000058 00 00000000

// ==== bench/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

    import rv_core_pkg::*;

    localparam int reset_cycles      = 16;
    localparam int cycles_per_record = 8;
    localparam int group_count       = 5;

    typedef struct packed {
        logic [2:0]      group;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] wdata;
    } expect_t;

    logic       clk;
    logic       rst;
    imem_load_t imem_load;
    retire_t    retire;

    expect_t         expect_q [$];
    logic [xlen-1:0] prog_addr_q [$];
    logic [xlen-1:0] prog_data_q [$];

    int   cycle_count;
    int   cycle_limit;
    int   error_count;
    int   check_count;
    int   retired_count;
    int   expected_total;
    logic timed_out;
    int   group_total [1:group_count];
    int   group_seen [1:group_count];
    int   group_errors [1:group_count];

    core dut_i (
        .clk       (clk),
        .rst       (rst),
        .imem_load (imem_load),
        .retire    (retire)
    );

    always #20 clk = ~clk;

    function automatic string group_name(input int group);
        case (group)
            1:       group_name = "alu register ops";
            2:       group_name = "immediate path";
            3:       group_name = "store then load";
            4:       group_name = "branches";
            5:       group_name = "x0 rule";
            default: group_name = "unknown group";
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus file.
    //////////////////////////////////////////////////////////////////////

    task automatic read_stimulus();
        int               fd;
        int               code;
        int               group;
        logic             done;
        logic [7:0]       tag;
        logic [xlen-1:0]  addr;
        logic [xlen-1:0]  word;
        logic [xlen-1:0]  pc;
        logic [4:0]       rd;
        logic [xlen-1:0]  wdata;
        logic [8*256-1:0] rest;
        expect_t          rec;
        fd = $fopen("bench/core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/core_stimulus.txt");
            error_count++;
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, " %c", tag);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tag == "#") begin
                    code = $fgets(rest, fd);
                end else if (tag == "P") begin
                    code = $fscanf(fd, "%h %h", addr, word);
                    if (code != 2) begin
                        $display("malformed program line in stimulus file");
                        error_count++;
                        done = 1'b1;
                    end else begin
                        prog_addr_q.push_back(addr);
                        prog_data_q.push_back(word);
                    end
                end else if (tag == "E") begin
                    code = $fscanf(fd, "%d %h %h %h", group, pc, rd, wdata);
                    if (code != 4 || group < 1 || group > group_count) begin
                        $display("malformed expected record in stimulus file");
                        error_count++;
                        done = 1'b1;
                    end else begin
                        rec.group = 3'(group);
                        rec.pc    = pc;
                        rec.rd    = rd;
                        rec.wdata = wdata;
                        expect_q.push_back(rec);
                    end
                end else begin
                    $display("unknown record tag in stimulus file");
                    error_count++;
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end
    endtask

    // inputs change on the falling edge only.
    task automatic step_cycle();
        @(negedge clk);
        cycle_count++;
    endtask

    task automatic load_program();
        logic [xlen-1:0] load_addr;
        for (int i = 0; i < prog_data_q.size(); i++) begin
            step_cycle();
            load_addr       = prog_addr_q[i];
            imem_load.valid = 1'b1;
            imem_load.addr  = load_addr[imem_aw+1:2];
            imem_load.data  = prog_data_q[i];
        end
        step_cycle();
        imem_load = '0;
        repeat (reset_cycles) begin
            step_cycle();
        end
        rst = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // retire trace checking.
    //////////////////////////////////////////////////////////////////////

    task automatic check_retire();
        expect_t exp_rec;
        int      group;
        logic    bad;
        exp_rec = expect_q.pop_front();
        group   = int'(exp_rec.group);
        bad     = 1'b0;
        check_count++;
        if (retire.pc !== exp_rec.pc) begin
            $display("Mismatch retire.pc: expected 0x%08h, actual 0x%08h",
                     exp_rec.pc, retire.pc);
            bad = 1'b1;
        end
        if (retire.rd !== exp_rec.rd) begin
            $display("Mismatch retire.rd at pc 0x%08h: expected 0x%02h, actual 0x%02h",
                     exp_rec.pc, exp_rec.rd, retire.rd);
            bad = 1'b1;
        end
        if (retire.wdata !== exp_rec.wdata) begin
            $display("Mismatch retire.wdata at pc 0x%08h: expected 0x%08h, actual 0x%08h",
                     exp_rec.pc, exp_rec.wdata, retire.wdata);
            bad = 1'b1;
        end
        if (bad) begin
            error_count++;
            group_errors[group]++;
        end
        retired_count++;
        group_seen[group]++;
        if (group_seen[group] == group_total[group]) begin
            $display("%s: %0d records checked, %0d mismatched",
                     group_name(group), group_seen[group], group_errors[group]);
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        imem_load      = '0;
        cycle_count    = 0;
        error_count    = 0;
        check_count    = 0;
        retired_count  = 0;
        timed_out      = 1'b0;
        for (int g = 1; g <= group_count; g++) begin
            group_total[g]  = 0;
            group_seen[g]   = 0;
            group_errors[g] = 0;
        end

        read_stimulus();
        expected_total = expect_q.size();
        if (expected_total == 0) begin
            $display("no expected retire records were found in the stimulus file");
            error_count++;
        end
        for (int i = 0; i < expected_total; i++) begin
            group_total[int'(expect_q[i].group)]++;
        end
        cycle_limit = reset_cycles + prog_data_q.size() + cycles_per_record * expected_total;

        load_program();

        // the program parks on a self loop, so retires never run dry.
        while (expect_q.size() > 0 && !timed_out) begin
            step_cycle();
            if (retire.valid === 1'b1) begin
                check_retire();
            end
            if (expect_q.size() > 0 && cycle_count >= cycle_limit) begin
                timed_out = 1'b1;
                $display("timeout after %0d cycles, %0d expected records never retired",
                         cycle_count, expect_q.size());
            end
        end

        $display("order and completeness: %0d of %0d expected records retired",
                 retired_count, expected_total);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== core.f ====
hdl/rv_core_pkg.sv
hdl/instruction_memory.sv
hdl/data_memory.sv
hdl/register_bank.sv
hdl/alu_encapsulator.sv
hdl/pc_unit.sv
hdl/main_controller.sv
hdl/core.sv
bench/core_tb.sv

// ==== hdl/alu_encapsulator.sv ====
`timescale 1ns/1ps

module alu_encapsulator (
    input  rv_core_pkg::instr_word_u     instr,
    input  rv_core_pkg::ctrl_t           ctrl,
    input  logic [rv_core_pkg::xlen-1:0] pc,
    input  logic [rv_core_pkg::xlen-1:0] rs1_data,
    input  logic [rv_core_pkg::xlen-1:0] rs2_data,
    output logic [rv_core_pkg::xlen-1:0] result,
    output logic [rv_core_pkg::xlen-1:0] branch_target,
    output logic                         branch_taken
);

    import rv_core_pkg::*;

    logic [xlen-1:0] imm;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] operand_b;
    alu_op_e         alu_op;

    //////////////////////////////////////////////////////////////////////
    // immediate generator.
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (instr.r_view.opcode == op_store) begin
            imm = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_hi, instr.s_view.imm_lo};
        end else begin
            imm = {{20{instr.i_view.imm12[11]}}, instr.i_view.imm12};
        end
    end

    // b-type bits are spread over both halves of the s layout.
    assign imm_b = {{20{instr.s_view.imm_hi[6]}}, instr.s_view.imm_lo[0],
                    instr.s_view.imm_hi[5:0], instr.s_view.imm_lo[4:1], 1'b0};

    //////////////////////////////////////////////////////////////////////
    // function decode and ALU.
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_op = alu_add;
        if (instr.r_view.opcode == op_reg || instr.r_view.opcode == op_imm) begin
            case (instr.r_view.funct3)
                3'b000: begin
                    if (instr.r_view.opcode == op_reg && instr.r_view.funct7[5]) begin
                        alu_op = alu_sub;
                    end else begin
                        alu_op = alu_add;
                    end
                end
                3'b010:  alu_op = alu_slt;
                3'b100:  alu_op = alu_xor;
                3'b110:  alu_op = alu_or;
                3'b111:  alu_op = alu_and;
                default: alu_op = alu_add;
            endcase
        end
    end

    assign operand_b = ctrl.alu_src_imm ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            alu_add: result = rs1_data + operand_b;
            alu_sub: result = rs1_data - operand_b;
            alu_and: result = rs1_data & operand_b;
            alu_or:  result = rs1_data | operand_b;
            alu_xor: result = rs1_data ^ operand_b;
            alu_slt: result = xlen'($signed(rs1_data) < $signed(operand_b));
            default: result = '0;
        endcase
    end

    assign branch_target = pc + imm_b;
    assign branch_taken  = (rs1_data == rs2_data);

endmodule

// ==== hdl/core.sv ====
`timescale 1ns/1ps

module core (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_core_pkg::imem_load_t imem_load,
    output rv_core_pkg::retire_t    retire
);

    import rv_core_pkg::*;

    instr_word_u     fetch_data;
    instr_word_u     ir;
    core_state_e     state;
    ctrl_t           ctrl;
    wb_req_t         wb_req;
    wb_rsp_t         wb_rsp;
    logic            pc_advance;
    logic            ir_load;
    logic            branch_taken;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] branch_target;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] wb_q;

    //////////////////////////////////////////////////////////////////////
    // sequencing.
    //////////////////////////////////////////////////////////////////////

    main_controller main_controller_i (
        .clk        (clk),
        .rst        (rst),
        .instr      (fetch_data),
        .wb_rsp     (wb_rsp),
        .alu_result (alu_result),
        .store_data (rs2_data),
        .state      (state),
        .ctrl       (ctrl),
        .wb_req     (wb_req),
        .pc_advance (pc_advance),
        .ir_load    (ir_load)
    );

    pc_unit pc_unit_i (
        .clk           (clk),
        .rst           (rst),
        .pc_advance    (pc_advance),
        .take_branch   (ctrl.is_branch && branch_taken),
        .branch_target (branch_target),
        .pc            (pc)
    );

    instruction_memory instruction_memory_i (
        .clk        (clk),
        .load       (imem_load),
        .fetch_addr (pc),
        .fetch_data (fetch_data)
    );

    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir <= fetch_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // datapath.
    //////////////////////////////////////////////////////////////////////

    register_bank register_bank_i (
        .clk        (clk),
        .rst        (rst),
        .rs1        (ir.r_view.rs1),
        .rs2        (ir.r_view.rs2),
        .rd         (ir.r_view.rd),
        .write_en   (ctrl.reg_write && state == writeback),
        .write_data (wb_q),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    alu_encapsulator alu_encapsulator_i (
        .instr         (ir),
        .ctrl          (ctrl),
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .result        (alu_result),
        .branch_target (branch_target),
        .branch_taken  (branch_taken)
    );

    data_memory data_memory_i (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    // alu result at the end of execute, load data on ack.
    always_ff @(posedge clk) begin
        if ((state == execute && !ctrl.wb_from_mem) || (state == memory && wb_rsp.ack)) begin
            wb_q <= ctrl.wb_from_mem ? wb_rsp.dat_r : alu_result;
        end
    end

    assign retire.valid = (state == writeback);
    assign retire.pc    = pc;
    assign retire.rd    = ctrl.reg_write ? ir.r_view.rd : 5'd0;
    assign retire.wdata = ctrl.reg_write ? wb_q : '0;

endmodule

// ==== hdl/data_memory.sv ====
`timescale 1ns/1ps

module data_memory (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_core_pkg::wb_req_t wb_req,
    output rv_core_pkg::wb_rsp_t wb_rsp
);

    import rv_core_pkg::*;

    logic [xlen-1:0]    mem [dmem_depth];
    logic [dmem_aw-1:0] word_idx;
    logic               req;
    logic               ack_q;
    logic [xlen-1:0]    rdata_q;

    assign word_idx = wb_req.adr[dmem_aw+1:2];

    // a new request only while no ack is out.
    assign req = wb_req.cyc && wb_req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req && wb_req.we) begin
            mem[word_idx] <= wb_req.dat_w;
        end
        if (req) begin
            rdata_q <= mem[word_idx];
        end
    end

    assign wb_rsp = '{ack: ack_q, dat_r: rdata_q};

    a_single_ack: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack);

    // the master must hold its request until the ack arrives.
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb));

endmodule

// ==== hdl/instruction_memory.sv ====
`timescale 1ns/1ps

module instruction_memory (
    input  logic                         clk,
    input  rv_core_pkg::imem_load_t      load,
    input  logic [rv_core_pkg::xlen-1:0] fetch_addr,
    output rv_core_pkg::instr_word_u     fetch_data
);

    import rv_core_pkg::*;

    logic [xlen-1:0]    mem [imem_depth];
    logic [imem_aw-1:0] fetch_idx;

    // byte address in, word index out.
    assign fetch_idx = fetch_addr[imem_aw+1:2];

    always_ff @(posedge clk) begin
        if (load.valid) begin
            mem[load.addr] <= load.data;
        end
    end

    // registered read, data follows the address by one cycle.
    always_ff @(posedge clk) begin
        fetch_data <= mem[fetch_idx];
    end

endmodule

// ==== hdl/main_controller.sv ====
`timescale 1ns/1ps

module main_controller (
    input  logic                         clk,
    input  logic                         rst,
    input  rv_core_pkg::instr_word_u     instr,
    input  rv_core_pkg::wb_rsp_t         wb_rsp,
    input  logic [rv_core_pkg::xlen-1:0] alu_result,
    input  logic [rv_core_pkg::xlen-1:0] store_data,
    output rv_core_pkg::core_state_e     state,
    output rv_core_pkg::ctrl_t           ctrl,
    output rv_core_pkg::wb_req_t         wb_req,
    output logic                         pc_advance,
    output logic                         ir_load
);

    import rv_core_pkg::*;

    core_state_e state_next;

    // opcode decode, the fetch register holds the word until writeback ends.
    always_comb begin
        ctrl = '0;
        case (instr.r_view.opcode)
            op_reg: begin
                ctrl.reg_write = 1'b1;
            end
            op_imm: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            op_load: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.wb_from_mem = 1'b1;
            end
            op_store: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            op_branch: begin
                ctrl.is_branch = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // phase sequencer.
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            fetch:     state_next = decode;
            decode:    state_next = execute;
            execute:   state_next = (ctrl.mem_read || ctrl.mem_write) ? memory : writeback;
            memory:    state_next = wb_rsp.ack ? writeback : memory;
            writeback: state_next = fetch;
            default:   state_next = fetch;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch;
        end else begin
            state <= state_next;
        end
    end

    // wishbone master, address and write data latched at the end of execute.
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            wb_req.we  <= 1'b0;
        end else if (state == execute && state_next == memory) begin
            wb_req.cyc   <= 1'b1;
            wb_req.stb   <= 1'b1;
            wb_req.we    <= ctrl.mem_write;
            wb_req.adr   <= alu_result;
            wb_req.dat_w <= store_data;
        end else if (wb_rsp.ack) begin
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            wb_req.we  <= 1'b0;
        end
    end

    assign pc_advance = (state == writeback);
    assign ir_load    = (state == decode);

    a_stb_needs_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_req.stb |-> wb_req.cyc);

    a_memory_waits_ack: assert property (@(posedge clk) disable iff (rst)
        (state == memory && !wb_rsp.ack) |=> state == memory);

endmodule

// ==== hdl/pc_unit.sv ====
`timescale 1ns/1ps

module pc_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pc_advance,
    input  logic                         take_branch,
    input  logic [rv_core_pkg::xlen-1:0] branch_target,
    output logic [rv_core_pkg::xlen-1:0] pc
);

    import rv_core_pkg::*;

    logic [xlen-1:0] pc_next;

    // sequential successor unless a taken beq redirects.
    always_comb begin
        if (take_branch) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + xlen'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_advance) begin
            pc <= pc_next;
        end
    end

    // a misaligned branch target would show up here.
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule

// ==== hdl/register_bank.sv ====
`timescale 1ns/1ps

module register_bank (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [4:0]                   rs1,
    input  logic [4:0]                   rs2,
    input  logic [4:0]                   rd,
    input  logic                         write_en,
    input  logic [rv_core_pkg::xlen-1:0] write_data,
    output logic [rv_core_pkg::xlen-1:0] rs1_data,
    output logic [rv_core_pkg::xlen-1:0] rs2_data
);

    import rv_core_pkg::*;

    // x0 is cleared by reset and its write is gated off.
    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && rd != 5'd0) begin
            regs[rd] <= write_data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    a_x0_reads_zero_rs1: assert property (@(posedge clk) disable iff (rst)
        rs1 == 5'd0 |-> rs1_data == '0);

    a_x0_reads_zero_rs2: assert property (@(posedge clk) disable iff (rst)
        rs2 == 5'd0 |-> rs2_data == '0);

endmodule

// ==== hdl/rv_core_pkg.sv ====
package rv_core_pkg;

    localparam int xlen       = 32;
    localparam int imem_depth = 256;
    localparam int dmem_depth = 256;
    localparam int imem_aw    = $clog2(imem_depth);
    localparam int dmem_aw    = $clog2(dmem_depth);

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    //////////////////////////////////////////////////////////////////////
    // instruction word layouts.
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // beq shares this layout, only the immediate bits are scrambled.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
        s_view_t s_view;
    } instr_word_u;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    typedef enum logic [2:0] {
        fetch,
        decode,
        execute,
        memory,
        writeback
    } core_state_e;

    //////////////////////////////////////////////////////////////////////
    // control, bus and trace bundles.
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic reg_write;
        logic alu_src_imm;
        logic mem_read;
        logic mem_write;
        logic is_branch;
        logic wb_from_mem;
    } ctrl_t;

    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [xlen-1:0] adr;
        logic [xlen-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [xlen-1:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic               valid;
        logic [imem_aw-1:0] addr;
        logic [xlen-1:0]    data;
    } imem_load_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] wdata;
    } retire_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --assert --top-module core_tb -f core.f --Mdir obj_dir -o core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/core_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "$sim_output" | grep -q "^Result: PASSED$"
if [ $? -ne 0 ]; then
    echo "simulation did not report a pass"
    exit 1
fi

exit 0
